//--- Makefile
# Verilator build and run of the trace unit testbench

VERILATOR ?= verilator
TOP       ?= tb_instr_tracer
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= TEST RESULT: PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- bench/tb_instr_tracer.sv
//////////////////////////////////////////////////
// testbench for the trace unit where an in-order core model
// drives id/ex/wb and accepted records are checked in order
//////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_instr_tracer
  import trace_pkg::*;
();

  localparam int out_depth = 4;
  localparam int n_mixed   = 64;
  localparam int n_burst   = out_depth + 3;
  localparam int n_tail    = 24;
  localparam int n_total   = n_mixed + n_burst + n_tail;
  localparam int max_instr = 128;

  // instruction kinds of the stimulus table
  localparam instr_class_e kind_cls [15] = '{
    cls_nop, cls_lui, cls_auipc, cls_jal, cls_jalr, cls_branch, cls_load, cls_store,
    cls_op_imm, cls_op, cls_fence, cls_system, cls_system, cls_invalid, cls_invalid
  };
  localparam logic [6:0] kind_opc [15] = '{
    opcode_op_imm, opcode_lui, opcode_auipc, opcode_jal, opcode_jalr, opcode_branch,
    opcode_load, opcode_store, opcode_op_imm, opcode_op, opcode_fence, opcode_system,
    opcode_system, 7'b0000000, 7'b1111111
  };

  logic          clk;
  logic          rst_n;
  logic          id_valid;
  logic          is_decoding;
  xlen_t         pc;
  xlen_t         instr;
  ex_port_t      ex;
  logic          wb_bypass;
  wb_port_t      wb;
  logic          trace_valid;
  trace_record_t trace;
  logic          trace_ready;
  xlen_t         drop_count;

  logic [31:0]   lfsr;
  xlen_t         cycle_model;
  string         test_name;
  int            err_count;
  int            check_count;
  int            accepted;
  int            exp_drops;
  int            ref_q[$];
  trace_record_t exp_rec [max_instr];
  logic          exp_byp [max_instr];

  // core model slots hold record indices
  int            occ;
  int            next_idx;
  int            pend_idx;
  xlen_t         pc_next;
  logic          ex_busy;
  int            ex_idx;
  int            ex_left;
  logic          wb_busy;
  int            wb_idx;
  int            wb_left;
  logic          rel_drv;
  logic          drop_drv;
  logic          rdy_drv;
  logic          ex_drv;
  logic          id_drv;

  instr_tracer #(
    .EX_DEPTH  (2),
    .WB_DEPTH  (2),
    .OUT_DEPTH (out_depth)
  ) i_instr_tracer (
    .clk         (clk),
    .rst_n       (rst_n),
    .id_valid    (id_valid),
    .is_decoding (is_decoding),
    .pc          (pc),
    .instr       (instr),
    .ex          (ex),
    .wb_bypass   (wb_bypass),
    .wb          (wb),
    .trace_valid (trace_valid),
    .trace       (trace),
    .trace_ready (trace_ready),
    .drop_count  (drop_count)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // fibonacci lfsr with taps 32 22 2 1
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      r    = {r[30:0], fb};
    end
    return r;
  endfunction

  task automatic check_field(input string field, input logic [31:0] exp_v,
                             input logic [31:0] act_v);
    check_count++;
    assert (exp_v == act_v) else begin
      $display("ERR %s: %s expected %h actual %h", test_name, field, exp_v, act_v);
      err_count++;
    end
  endtask

  // counter value seen at each edge starts at zero after release
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cycle_model <= '0;
    end else begin
      cycle_model <= cycle_model + 32'd1;
    end
  end

  //////////////////////////////////////////////////
  // instruction table and expected decode fields
  //////////////////////////////////////////////////

  task automatic build_instr(input int idx, output xlen_t w);
    int          kind;
    logic [16:0] hi;
    logic [2:0]  f3;
    reg_addr_t   rd;
    logic [6:0]  opc;
    logic        writes;
    kind = int'(take_bits(4) % 15);
    hi   = 17'(take_bits(17));
    f3   = 3'(take_bits(3));
    rd   = (take_bits(2) == 0) ? 5'd0 : 5'(take_bits(5));
    opc  = kind_opc[kind];
    if (kind == 11) f3 = 3'(take_bits(2)) + 3'd1;
    if (kind == 12) f3 = 3'd0;
    if (kind == 13) opc = {5'(take_bits(5)), 2'b00};
    w = {hi, f3, rd, opc};
    if (kind == 8) w[20] = 1'b1;
    if (kind == 0) w = 32'h0000_0013;
    writes = kind inside {1, 2, 3, 4, 6, 8, 9, 11};
    exp_rec[idx]            = '0;
    exp_rec[idx].id.pc      = pc_next;
    exp_rec[idx].id.instr   = w;
    exp_rec[idx].id.iclass  = kind_cls[kind];
    exp_rec[idx].id.rd      = w[11:7];
    exp_rec[idx].id.rd_used = writes && (w[11:7] != 5'd0);
    exp_byp[idx]            = kind inside {3, 5};
    pc_next                 = pc_next + 32'd4;
  endtask

  task automatic drive_idle();
    ex          <= '0;
    wb          <= '0;
    wb_bypass   <= 1'b0;
    id_valid    <= 1'b0;
    is_decoding <= 1'b0;
    trace_ready <= 1'b0;
    rel_drv  = 1'b0;
    drop_drv = 1'b0;
    rdy_drv  = 1'b0;
    ex_drv   = 1'b0;
    id_drv   = 1'b0;
  endtask

  //////////////////////////////////////////////////
  // core model runs one pass per rising edge
  //////////////////////////////////////////////////

  task automatic run_phase(input int n, input logic burst);
    int       issued;
    logic     wb_go;
    logic     ex_go;
    logic     give;
    logic     gap;
    logic     rdy;
    logic     byp_s;
    ex_port_t ex_s;
    wb_port_t wb_s;
    xlen_t    w;
    issued = 0;
    forever begin
      @(posedge clk);
      // what happened at this edge
      if (occ > 0 && rdy_drv) occ--;
      if (rel_drv && !drop_drv) occ++;
      if (rel_drv) wb_busy = 1'b0;
      if (ex_drv) begin
        wb_busy = 1'b1;
        wb_idx  = ex_idx;
        wb_left = int'(take_bits(2) % 3) + 1;
        ex_busy = 1'b0;
      end
      if (id_drv) begin
        ex_busy = 1'b1;
        ex_idx  = pend_idx;
        ex_left = int'(take_bits(2) % 3) + 1;
        exp_rec[ex_idx].id.cycle = cycle_model;
      end
      if (issued == n && !ex_busy && !wb_busy && occ == 0) begin
        drive_idle();
        break;
      end

      // writeback slot
      wb_go = 1'b0;
      wb_s  = '0;
      if (wb_busy && exp_byp[wb_idx]) begin
        wb_go = 1'b1;
      end else if (wb_busy) begin
        wb_s.reg_we    = 1'(take_bits(1));
        wb_s.reg_addr  = take_bits(1) ? exp_rec[wb_idx].id.rd : 5'(take_bits(5));
        wb_s.reg_wdata = take_bits(32);
        if (wb_left == 1) wb_go = 1'b1;
        else wb_left--;
        wb_s.valid = wb_go;
        if (wb_s.reg_we && exp_rec[wb_idx].id.rd_used &&
            wb_s.reg_addr == exp_rec[wb_idx].id.rd) begin
          exp_rec[wb_idx].rd_value = wb_s.reg_wdata;
          exp_rec[wb_idx].rd_seen  = 1'b1;
        end
      end
      // a full output queue discards the completed record
      if (wb_go && occ == out_depth) exp_drops++;
      else if (wb_go) ref_q.push_back(wb_idx);

      // execute slot
      ex_go = 1'b0;
      ex_s  = '0;
      byp_s = 1'b0;
      if (ex_busy) begin
        ex_s.reg_we    = 1'(take_bits(1));
        ex_s.reg_addr  = take_bits(1) ? exp_rec[ex_idx].id.rd : 5'(take_bits(5));
        ex_s.reg_wdata = take_bits(32);
        if (exp_rec[ex_idx].id.iclass inside {cls_load, cls_store}) begin
          ex_s.data_req  = 1'(take_bits(1));
          ex_s.data_gnt  = 1'(take_bits(1));
          ex_s.data_we   = (exp_rec[ex_idx].id.iclass == cls_store);
          ex_s.data_addr = take_bits(32);
        end
        if (ex_s.reg_we && exp_rec[ex_idx].id.rd_used &&
            ex_s.reg_addr == exp_rec[ex_idx].id.rd) begin
          exp_rec[ex_idx].rd_value = ex_s.reg_wdata;
          exp_rec[ex_idx].rd_seen  = 1'b1;
        end
        if (ex_s.data_req && ex_s.data_gnt) begin
          exp_rec[ex_idx].mem_valid = 1'b1;
          exp_rec[ex_idx].mem_we    = ex_s.data_we;
          exp_rec[ex_idx].mem_addr  = ex_s.data_addr;
        end
        if (ex_left > 1) ex_left--;
        else if (!wb_busy || wb_go) ex_go = 1'b1;
        ex_s.valid = ex_go && !exp_byp[ex_idx];
        byp_s      = ex_go && exp_byp[ex_idx];
      end

      // decode gaps never raise both strobes
      give = (issued < n) && (!ex_busy || ex_go) && (take_bits(2) != 0);
      gap  = 1'(take_bits(1));
      if (give) begin
        pend_idx = next_idx;
        build_instr(pend_idx, w);
        next_idx++;
        issued++;
        pc    <= exp_rec[pend_idx].id.pc;
        instr <= w;
      end
      if (burst) rdy = (issued == n) && !ex_busy && !wb_busy;
      else rdy = (take_bits(2) != 0);

      id_valid    <= give | gap;
      is_decoding <= give | ~gap;
      ex          <= ex_s;
      wb_bypass   <= byp_s;
      wb          <= wb_s;
      trace_ready <= rdy;
      drop_drv = wb_go && (occ == out_depth);
      rel_drv  = wb_go;
      rdy_drv  = rdy;
      ex_drv   = ex_go;
      id_drv   = give;
    end
    // phase results are sampled away from the last edge
    @(negedge clk);
  endtask

  //////////////////////////////////////////////////
  // checks on the record stream
  //////////////////////////////////////////////////

  always @(posedge clk) begin : accept_check
    int            idx;
    trace_record_t e;
    if (rst_n && trace_valid && trace_ready) begin
      if (ref_q.size() == 0) begin
        $display("record for pc %h accepted while none was expected", trace.id.pc);
        err_count++;
      end else begin
        idx = ref_q.pop_front();
        e   = exp_rec[idx];
        accepted++;
        check_field("cycle", e.id.cycle, trace.id.cycle);
        check_field("pc", e.id.pc, trace.id.pc);
        check_field("instr", e.id.instr, trace.id.instr);
        check_field("iclass", 32'(e.id.iclass), 32'(trace.id.iclass));
        check_field("rd", 32'(e.id.rd), 32'(trace.id.rd));
        check_field("rd_used", 32'(e.id.rd_used), 32'(trace.id.rd_used));
        check_field("rd_seen", 32'(e.rd_seen), 32'(trace.rd_seen));
        if (e.rd_seen) check_field("rd_value", e.rd_value, trace.rd_value);
        check_field("mem_valid", 32'(e.mem_valid), 32'(trace.mem_valid));
        if (e.mem_valid) begin
          check_field("mem_we", 32'(e.mem_we), 32'(trace.mem_we));
          check_field("mem_addr", e.mem_addr, trace.mem_addr);
        end
      end
    end
  end

  a_trace_hold: assert property (
    @(posedge clk) disable iff (!rst_n)
      trace_valid && !trace_ready |=> trace_valid && $stable(trace)
  ) else begin
    $display("trace record changed or vanished before it was accepted");
    err_count++;
  end

  // watchdog
  initial begin
    repeat (n_total * 20 + 16) @(posedge clk);
    $display("watchdog expired after %0d records, the stream stalled", accepted);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial begin
    rst_n       = 1'b0;
    id_valid    = 1'b0;
    is_decoding = 1'b0;
    pc          = '0;
    instr       = '0;
    ex          = '0;
    wb_bypass   = 1'b0;
    wb          = '0;
    trace_ready = 1'b0;
    lfsr        = 32'ha56a20b1;
    pc_next     = 32'h0000_1000;
    ex_busy     = 1'b0;
    wb_busy     = 1'b0;
    test_name   = "reset_state";
    drive_idle();
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    repeat (3) @(posedge clk);
    check_field("trace_valid", 32'd0, 32'(trace_valid));
    check_field("drop_count", 32'd0, drop_count);

    test_name = "classify_order";
    run_phase(n_mixed, 1'b0);
    check_field("drop_count", exp_drops, drop_count);
    // with ready held low only out_depth records survive
    test_name = "backpressure";
    run_phase(n_burst, 1'b1);
    check_field("drop_count", exp_drops, drop_count);
    test_name = "mixed_tail";
    run_phase(n_tail, 1'b0);
    check_field("drop_count", exp_drops, drop_count);
    check_field("records", next_idx - exp_drops, accepted);

    $display("checks %0d, records %0d, drops %0d, errors %0d",
             check_count, accepted, exp_drops, err_count);
    if (err_count == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- project.f
rtl/trace_pkg.sv
rtl/trace_fifo.sv
rtl/trace_decoder.sv
rtl/ex_tracker.sv
rtl/wb_tracker.sv
rtl/instr_tracer.sv
bench/tb_instr_tracer.sv

//--- rtl/ex_tracker.sv
//////////////////////////////////////////////////
// execute stage tracker, collects rd writes and data
// accesses for the oldest in-flight instruction
//////////////////////////////////////////////////

`timescale 1ns/1ps

module ex_tracker
  import trace_pkg::*;
#(
  parameter int EX_DEPTH = 2
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       id_push,
  input  id_record_t id_rec,
  input  ex_port_t   ex,
  input  logic       wb_bypass,
  output logic       ex_push,
  output ex_record_t ex_rec
);

  logic       q_push;
  logic       q_pop;
  logic       q_empty;
  logic       q_full;
  id_record_t q_head;
  logic       head_valid;
  id_record_t head;
  logic       leave;
  logic       rd_hit;
  logic       mem_hit;

  // capture register beside the head
  xlen_t      cap_rd_value;
  logic       cap_rd_seen;
  logic       cap_mem_valid;
  logic       cap_mem_we;
  xlen_t      cap_mem_addr;

  // fresh record falls through an empty queue, so the
  // instruction is tracked in its very first ex cycle
  assign head_valid = ~q_empty | id_push;
  assign head       = q_empty ? id_rec : q_head;
  assign leave      = head_valid & (ex.valid | wb_bypass);
  assign q_push     = id_push & ~(q_empty & leave);
  assign q_pop      = leave & ~q_empty;

  trace_fifo #(
    .DEPTH (EX_DEPTH),
    .WIDTH ($bits(id_record_t))
  ) i_ex_fifo (
    .clk   (clk),
    .rst_n (rst_n),
    .push  (q_push),
    .wdata (id_rec),
    .pop   (q_pop),
    .rdata (q_head),
    .empty (q_empty),
    .full  (q_full)
  );

  assign rd_hit  = head_valid & head.rd_used & ex.reg_we & (ex.reg_addr == head.rd);
  assign mem_hit = head_valid & ex.data_req & ex.data_gnt;

  //////////////////////////////////////////////////
  // outgoing record, includes this cycle's updates
  //////////////////////////////////////////////////

  always_comb begin
    ex_rec.id        = head;
    ex_rec.rd_value  = rd_hit ? ex.reg_wdata : cap_rd_value;
    ex_rec.rd_seen   = rd_hit | cap_rd_seen;
    ex_rec.mem_valid = mem_hit | cap_mem_valid;
    ex_rec.mem_we    = mem_hit ? ex.data_we : cap_mem_we;
    ex_rec.mem_addr  = mem_hit ? ex.data_addr : cap_mem_addr;
    ex_rec.bypass    = wb_bypass;
  end

  assign ex_push = leave;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cap_rd_seen   <= 1'b0;
      cap_mem_valid <= 1'b0;
    end else if (leave) begin
      cap_rd_seen   <= 1'b0;
      cap_mem_valid <= 1'b0;
    end else begin
      cap_rd_seen   <= ex_rec.rd_seen;
      cap_mem_valid <= ex_rec.mem_valid;
    end
  end

  always_ff @(posedge clk) begin
    cap_rd_value <= ex_rec.rd_value;
    cap_mem_we   <= ex_rec.mem_we;
    cap_mem_addr <= ex_rec.mem_addr;
  end

  a_ex_no_overflow: assert property (
    @(posedge clk) disable iff (!rst_n) id_push |-> !(q_full && q_push)
  ) else $error("decode record pushed into a full execute queue");

endmodule

//--- rtl/instr_tracer.sv
//////////////////////////////////////////////////
// instruction trace unit top, attach to the core's id/ex/wb
// ports and drain one record per retired instruction
//////////////////////////////////////////////////

`timescale 1ns/1ps

module instr_tracer
  import trace_pkg::*;
#(
  parameter int EX_DEPTH  = 2,
  parameter int WB_DEPTH  = 2,
  parameter int OUT_DEPTH = 4
) (
  input  logic          clk,
  input  logic          rst_n,
  input  logic          id_valid,
  input  logic          is_decoding,
  input  xlen_t         pc,
  input  xlen_t         instr,
  input  ex_port_t      ex,
  input  logic          wb_bypass,
  input  wb_port_t      wb,
  output logic          trace_valid,
  output trace_record_t trace,
  input  logic          trace_ready,
  output xlen_t         drop_count
);

  logic          id_push;
  id_record_t    id_rec;
  logic          ex_push;
  ex_record_t    ex_rec;
  logic          out_push;
  trace_record_t out_rec;
  logic          out_full;
  logic          out_empty;
  logic          out_pop;

  // decode side
  trace_decoder i_trace_decoder (
    .clk         (clk),
    .rst_n       (rst_n),
    .id_valid    (id_valid),
    .is_decoding (is_decoding),
    .pc          (pc),
    .instr       (instr),
    .id_push     (id_push),
    .id_rec      (id_rec)
  );

  ex_tracker #(
    .EX_DEPTH (EX_DEPTH)
  ) i_ex_tracker (
    .clk       (clk),
    .rst_n     (rst_n),
    .id_push   (id_push),
    .id_rec    (id_rec),
    .ex        (ex),
    .wb_bypass (wb_bypass),
    .ex_push   (ex_push),
    .ex_rec    (ex_rec)
  );

  wb_tracker #(
    .WB_DEPTH (WB_DEPTH)
  ) i_wb_tracker (
    .clk        (clk),
    .rst_n      (rst_n),
    .ex_push    (ex_push),
    .ex_rec     (ex_rec),
    .wb         (wb),
    .out_full   (out_full),
    .out_push   (out_push),
    .out_rec    (out_rec),
    .drop_count (drop_count)
  );

  // output stream, head of queue is the presented record
  assign out_pop     = trace_ready & ~out_empty;
  assign trace_valid = ~out_empty;

  trace_fifo #(
    .DEPTH (OUT_DEPTH),
    .WIDTH ($bits(trace_record_t))
  ) i_out_fifo (
    .clk   (clk),
    .rst_n (rst_n),
    .push  (out_push),
    .wdata (out_rec),
    .pop   (out_pop),
    .rdata (trace),
    .empty (out_empty),
    .full  (out_full)
  );

endmodule

//--- rtl/trace_decoder.sv
//////////////////////////////////////////////////
// decode-time capture, classifies each decoded word
// and hands a stamped record to the execute tracker
//////////////////////////////////////////////////

`timescale 1ns/1ps

module trace_decoder
  import trace_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       id_valid,
  input  logic       is_decoding,
  input  xlen_t      pc,
  input  xlen_t      instr,
  output logic       id_push,
  output id_record_t id_rec
);

  xlen_t        cycle_cnt;
  instr_class_e cls;
  reg_addr_t    rd;
  logic [2:0]   funct3;
  logic         rd_used;
  logic         capture;

  // major opcode lookup with the nop alias first
  function automatic instr_class_e classify(xlen_t w);
    instr_class_e c;
    if (w == instr_nop) begin
      c = cls_nop;
    end else if (w[1:0] != 2'b11) begin
      c = cls_invalid;
    end else begin
      case (w[6:0])
        opcode_lui:    c = cls_lui;
        opcode_auipc:  c = cls_auipc;
        opcode_jal:    c = cls_jal;
        opcode_jalr:   c = cls_jalr;
        opcode_branch: c = cls_branch;
        opcode_load:   c = cls_load;
        opcode_store:  c = cls_store;
        opcode_op_imm: c = cls_op_imm;
        opcode_op:     c = cls_op;
        opcode_fence:  c = cls_fence;
        opcode_system: c = cls_system;
        default:       c = cls_invalid;
      endcase
    end
    return c;
  endfunction

  // free-running cycle count
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cycle_cnt <= '0;
    end else begin
      cycle_cnt <= cycle_cnt + 32'd1;
    end
  end

  assign capture = id_valid & is_decoding;
  assign rd      = instr[rd_lsb +: 5];
  assign funct3  = instr[funct3_lsb +: 3];

  always_comb begin
    cls = classify(instr);
    case (cls)
      cls_lui, cls_auipc, cls_jal, cls_jalr,
      cls_load, cls_op_imm, cls_op: rd_used = 1'b1;
      // csr accesses write rd, ecall/ebreak/wfi do not
      cls_system:                   rd_used = (funct3 != 3'b000);
      default:                      rd_used = 1'b0;
    endcase
    if (rd == '0) begin
      rd_used = 1'b0;
    end
  end

  //////////////////////////////////////////////////
  // record register
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      id_push <= 1'b0;
    end else begin
      id_push <= capture;
    end
  end

  always_ff @(posedge clk) begin
    if (capture) begin
      id_rec.cycle   <= cycle_cnt;
      id_rec.pc      <= pc;
      id_rec.instr   <= instr;
      id_rec.iclass  <= cls;
      id_rec.rd      <= rd;
      id_rec.rd_used <= rd_used;
    end
  end

endmodule

//--- rtl/trace_fifo.sv
//////////////////////////////////////////////////
// synchronous queue for stage buffers and output,
// head word is readable while not empty
//////////////////////////////////////////////////

`timescale 1ns/1ps

module trace_fifo #(
  parameter int DEPTH = 2,
  parameter int WIDTH = 32
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             push,
  input  logic [WIDTH-1:0] wdata,
  input  logic             pop,
  output logic [WIDTH-1:0] rdata,
  output logic             empty,
  output logic             full
);

  localparam int AW = $clog2(DEPTH);

  logic [WIDTH-1:0] mem [DEPTH];
  // extra msb is the wrap bit
  logic [AW:0]      wr_ptr;
  logic [AW:0]      rd_ptr;

  assign empty = (wr_ptr == rd_ptr);
  assign full  = (wr_ptr[AW] != rd_ptr[AW]) &&
                 (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
  assign rdata = mem[rd_ptr[AW-1:0]];

  //////////////////////////////////////////////////
  // pointers
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // storage
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr[AW-1:0]] <= wdata;
    end
  end

  a_no_underflow: assert property (
    @(posedge clk) disable iff (!rst_n) pop |-> !empty
  ) else $error("trace_fifo popped while empty");

endmodule

//--- rtl/trace_pkg.sv
//////////////////////////////////////////////////
// shared types for the instruction trace unit
// import into any module that handles trace records
//////////////////////////////////////////////////

package trace_pkg;

  typedef logic [31:0] xlen_t;
  typedef logic [4:0]  reg_addr_t;

  // coarse instruction class, one per major opcode
  typedef enum logic [3:0] {
    cls_nop     = 4'd0,
    cls_lui     = 4'd1,
    cls_auipc   = 4'd2,
    cls_jal     = 4'd3,
    cls_jalr    = 4'd4,
    cls_branch  = 4'd5,
    cls_load    = 4'd6,
    cls_store   = 4'd7,
    cls_op_imm  = 4'd8,
    cls_op      = 4'd9,
    cls_fence   = 4'd10,
    cls_system  = 4'd11,
    cls_invalid = 4'd12
  } instr_class_e;

  //////////////////////////////////////////////////
  // rv32i major opcodes and field positions
  //////////////////////////////////////////////////

  localparam logic [6:0] opcode_lui    = 7'b0110111;
  localparam logic [6:0] opcode_auipc  = 7'b0010111;
  localparam logic [6:0] opcode_jal    = 7'b1101111;
  localparam logic [6:0] opcode_jalr   = 7'b1100111;
  localparam logic [6:0] opcode_branch = 7'b1100011;
  localparam logic [6:0] opcode_load   = 7'b0000011;
  localparam logic [6:0] opcode_store  = 7'b0100011;
  localparam logic [6:0] opcode_op_imm = 7'b0010011;
  localparam logic [6:0] opcode_op     = 7'b0110011;
  localparam logic [6:0] opcode_fence  = 7'b0001111;
  localparam logic [6:0] opcode_system = 7'b1110011;

  // addi x0, x0, 0
  localparam xlen_t instr_nop = 32'h0000_0013;

  localparam int rd_lsb     = 7;
  localparam int funct3_lsb = 12;

  //////////////////////////////////////////////////
  // stage records and core port bundles
  //////////////////////////////////////////////////

  typedef struct packed {
    xlen_t        cycle;
    xlen_t        pc;
    xlen_t        instr;
    instr_class_e iclass;
    reg_addr_t    rd;
    logic         rd_used;
  } id_record_t;

  typedef struct packed {
    id_record_t id;
    xlen_t      rd_value;
    logic       rd_seen;
    logic       mem_valid;
    logic       mem_we;
    xlen_t      mem_addr;
    logic       bypass;
  } ex_record_t;

  typedef struct packed {
    id_record_t id;
    xlen_t      rd_value;
    logic       rd_seen;
    logic       mem_valid;
    logic       mem_we;
    xlen_t      mem_addr;
  } trace_record_t;

  typedef struct packed {
    logic      valid;
    logic      reg_we;
    reg_addr_t reg_addr;
    xlen_t     reg_wdata;
    logic      data_req;
    logic      data_gnt;
    logic      data_we;
    xlen_t     data_addr;
  } ex_port_t;

  typedef struct packed {
    logic      valid;
    logic      reg_we;
    reg_addr_t reg_addr;
    xlen_t     reg_wdata;
  } wb_port_t;

endpackage

//--- rtl/wb_tracker.sv
//////////////////////////////////////////////////
// writeback stage tracker, final rd value and
// release of finished records into the output queue
//////////////////////////////////////////////////

`timescale 1ns/1ps

module wb_tracker
  import trace_pkg::*;
#(
  parameter int WB_DEPTH = 2
) (
  input  logic          clk,
  input  logic          rst_n,
  input  logic          ex_push,
  input  ex_record_t    ex_rec,
  input  wb_port_t      wb,
  input  logic          out_full,
  output logic          out_push,
  output trace_record_t out_rec,
  output xlen_t         drop_count
);

  logic       w_empty;
  logic       w_full;
  ex_record_t head;
  logic       rd_hit;
  logic       release_head;

  // wb value seen while the head waits
  xlen_t      cap_value;
  logic       cap_seen;

  trace_fifo #(
    .DEPTH (WB_DEPTH),
    .WIDTH ($bits(ex_record_t))
  ) i_wb_fifo (
    .clk   (clk),
    .rst_n (rst_n),
    .push  (ex_push),
    .wdata (ex_rec),
    .pop   (release_head),
    .rdata (head),
    .empty (w_empty),
    .full  (w_full)
  );

  assign rd_hit = ~w_empty & head.id.rd_used & wb.reg_we & (wb.reg_addr == head.id.rd);

  // bypass heads go out on their first cycle here
  assign release_head = ~w_empty & (head.bypass | wb.valid);
  assign out_push     = release_head & ~out_full;

  // a wb write wins over whatever ex saw
  always_comb begin
    out_rec.id        = head.id;
    out_rec.rd_value  = rd_hit   ? wb.reg_wdata :
                        cap_seen ? cap_value    : head.rd_value;
    out_rec.rd_seen   = rd_hit | cap_seen | head.rd_seen;
    out_rec.mem_valid = head.mem_valid;
    out_rec.mem_we    = head.mem_we;
    out_rec.mem_addr  = head.mem_addr;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cap_seen <= 1'b0;
    end else if (release_head) begin
      cap_seen <= 1'b0;
    end else if (rd_hit) begin
      cap_seen <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_hit) begin
      cap_value <= wb.reg_wdata;
    end
  end

  // completed records lost to a full output queue
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      drop_count <= '0;
    end else if (release_head && out_full) begin
      drop_count <= drop_count + 32'd1;
    end
  end

  a_wb_no_overflow: assert property (
    @(posedge clk) disable iff (!rst_n) ex_push |-> !(w_full && !release_head)
  ) else $error("execute record pushed into a full writeback queue");

endmodule
